// File: Bender.yml
package:
  name: ibuf

sources:
  - ibuf_pkg.sv
  - ibuf_fetch_queue.sv
  - ibuf_decode_slot.sv
  - ibuf_lane_pick.sv
  - ibuf_disp_merge.sv
  - ibuf_top.sv
  - target: test
    files:
      - ibuf_checker.sv
      - tb_ibuf.sv

// File: ibuf.f
ibuf_pkg.sv
ibuf_fetch_queue.sv
ibuf_decode_slot.sv
ibuf_lane_pick.sv
ibuf_disp_merge.sv
ibuf_top.sv
ibuf_checker.sv
tb_ibuf.sv

// File: ibuf_checker.sv
`timescale 1ns/10ps

module ibuf_checker import ibuf_pkg::*; (
  input logic                              i_clk,
  input logic                              i_reset_n,
  input logic                              i_disp_ready,
  input logic                              i_disp_valid,
  input logic [DISP_SIZE-1:0]              i_slot_valid,
  input logic [DISP_SIZE-1:0][31:0]        i_inst,
  input logic [DISP_SIZE-1:0][VADDR_W-1:0] i_pc,
  input inst_cat_t [DISP_SIZE-1:0]         i_cat
);

  logic [DISP_SIZE-1:0] w_mem_slot;

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_mem_slot[d] = (i_cat[d] == CAT_LD) || (i_cat[d] == CAT_ST);
    end
  end

  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_disp_valid && !i_disp_ready) |=> i_disp_valid && $stable(i_slot_valid)
      && $stable(i_inst) && $stable(i_pc) && $stable(i_cat))
    else $error("dispatch outputs changed under back-pressure");

  a_lane_limit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ($countones(i_slot_valid & ~w_mem_slot) <= ARITH_DISP_SIZE)
      && ($countones(i_slot_valid & w_mem_slot) <= MEM_DISP_SIZE))
    else $error("dispatch group exceeds lane limits");

  // valid slots must be 0..n-1 with no holes
  a_prefix: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ((i_slot_valid + 1'b1) & i_slot_valid) == '0)
    else $error("slot valid bits are not a contiguous prefix");

  a_reset_idle: assert property (@(posedge i_clk) !i_reset_n |-> !i_disp_valid)
    else $error("dispatch valid high during reset");

endmodule

// File: ibuf_decode_slot.sv
`timescale 1ns/10ps

module ibuf_decode_slot import ibuf_pkg::*; (
  input  logic [31:0] i_word,
  input  logic        i_word_valid,
  output inst_cat_t   o_cat,
  output logic        o_rd_valid,
  output logic        o_rs1_valid,
  output logic        o_rs2_valid,
  output logic        o_is_arith,
  output logic        o_is_mem
);

  logic [6:0] w_opc;
  logic       w_mem_class;

  assign w_opc = i_word[6:0];

  always_comb begin
    o_rd_valid  = 1'b1;
    o_rs1_valid = 1'b1;
    o_rs2_valid = 1'b0;
    case (w_opc)
      OPC_LOAD: begin
        o_cat = CAT_LD;
      end
      OPC_STORE: begin
        o_cat       = CAT_ST;
        o_rd_valid  = 1'b0;
        o_rs2_valid = 1'b1;
      end
      OPC_OP: begin
        o_cat       = CAT_ARITH;
        o_rs2_valid = 1'b1;
      end
      OPC_OP_IMM: begin
        o_cat = CAT_ARITH;
      end
      OPC_LUI, OPC_AUIPC: begin
        o_cat       = CAT_ARITH;
        o_rs1_valid = 1'b0;   // upper immediate only
      end
      default: begin
        o_cat = CAT_OTHER;    // still takes an arith lane
      end
    endcase
  end

  assign w_mem_class = (o_cat == CAT_LD) || (o_cat == CAT_ST);

  // anything not load/store goes to the arith lanes
  assign o_is_mem   = i_word_valid & w_mem_class;
  assign o_is_arith = i_word_valid & ~w_mem_class;

endmodule

// File: ibuf_disp_merge.sv
`timescale 1ns/10ps

module ibuf_disp_merge import ibuf_pkg::*; (
  input  logic [DISP_SIZE-1:0]              i_arith_pick,
  input  logic [DISP_SIZE-1:0]              i_mem_pick,
  input  logic [DISP_SIZE-1:0][31:0]        i_win_word,
  input  logic [VADDR_W-1:0]                i_head_pc,
  input  inst_cat_t [DISP_SIZE-1:0]         i_cat,
  input  logic [DISP_SIZE-1:0]              i_rd_valid,
  input  logic [DISP_SIZE-1:0]              i_rs1_valid,
  input  logic [DISP_SIZE-1:0]              i_rs2_valid,
  input  logic                              i_disp_ready,

  output logic [CNT_W-1:0]                  o_consume_cnt,

  output logic                              o_disp_valid,
  output logic [DISP_SIZE-1:0]              o_disp_slot_valid,
  output logic [DISP_SIZE-1:0][31:0]        o_disp_inst,
  output logic [DISP_SIZE-1:0][VADDR_W-1:0] o_disp_pc,
  output inst_cat_t [DISP_SIZE-1:0]         o_disp_cat,
  output logic [DISP_SIZE-1:0]              o_disp_rd_valid,
  output logic [DISP_SIZE-1:0]              o_disp_rs1_valid,
  output logic [DISP_SIZE-1:0]              o_disp_rs2_valid
);

  logic [DISP_SIZE-1:0] w_disp_or;
  logic [DISP_SIZE-1:0] w_disp_mask;
  logic [CNT_W-1:0]     w_disp_cnt;
  logic                 w_fire;

  assign w_disp_or = i_arith_pick | i_mem_pick;

  // stop at the first slot that no lane took
  always_comb begin
    logic run;
    run = 1'b1;
    for (int d = 0; d < DISP_SIZE; d++) begin
      run            = run & w_disp_or[d];
      w_disp_mask[d] = run;
    end
  end

  always_comb begin
    w_disp_cnt = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_disp_cnt = w_disp_cnt + CNT_W'(w_disp_mask[d]);
    end
  end

  assign o_disp_valid      = |w_disp_mask;
  assign o_disp_slot_valid = w_disp_mask;
  assign w_fire            = o_disp_valid & i_disp_ready;
  assign o_consume_cnt     = w_fire ? w_disp_cnt : '0;

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot
    always_comb begin
      if (w_disp_mask[d]) begin
        o_disp_inst[d]      = i_win_word[d];
        o_disp_pc[d]        = i_head_pc + VADDR_W'(4 * d);
        o_disp_cat[d]       = i_cat[d];
        o_disp_rd_valid[d]  = i_rd_valid[d];
        o_disp_rs1_valid[d] = i_rs1_valid[d];
        o_disp_rs2_valid[d] = i_rs2_valid[d];
      end else begin
        o_disp_inst[d]      = '0;
        o_disp_pc[d]        = '0;
        o_disp_cat[d]       = CAT_ARITH;   // zero encoding
        o_disp_rd_valid[d]  = 1'b0;
        o_disp_rs1_valid[d] = 1'b0;
        o_disp_rs2_valid[d] = 1'b0;
      end
    end
  end

endmodule

// File: ibuf_fetch_queue.sv
`timescale 1ns/10ps

module ibuf_fetch_queue import ibuf_pkg::*; (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_fetch_valid,
  output logic                       o_fetch_ready,
  input  logic [VADDR_W-1:0]         i_fetch_pc,
  input  logic [LINE_W-1:0]          i_fetch_line,

  input  logic [CNT_W-1:0]           i_consume_cnt,

  output logic [DISP_SIZE-1:0][31:0] o_win_word,
  output logic [DISP_SIZE-1:0]       o_win_valid,
  output logic [VADDR_W-1:0]         o_head_pc
);

  logic [LINE_W-1:0]        r_line [INST_BUF_SIZE];
  logic [VADDR_W-1:0]       r_pc   [INST_BUF_SIZE];
  logic [INST_BUF_SIZE-1:0] r_vld;
  logic [BUF_PTR_W-1:0]     r_in_ptr;
  logic [BUF_PTR_W-1:0]     r_out_ptr;
  logic [WORD_POS_W-1:0]    r_head_pos;

  logic                     w_push;
  logic                     w_pop;
  logic [CNT_W-1:0]         w_pos_sum;

  assign o_fetch_ready = ~(&r_vld);   // full only when every entry holds a line
  assign w_push        = i_fetch_valid & o_fetch_ready;

  // consume count is already zero when the group does not fire
  assign w_pos_sum = CNT_W'(r_head_pos) + i_consume_cnt;
  assign w_pop     = w_pos_sum >= CNT_W'(LINE_WORDS);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vld      <= '0;
      r_in_ptr   <= '0;
      r_out_ptr  <= '0;
      r_head_pos <= '0;
    end else begin
      if (w_push) begin
        r_vld[r_in_ptr] <= 1'b1;
        r_in_ptr        <= r_in_ptr + 1'b1;
      end
      if (w_pop) begin
        r_vld[r_out_ptr] <= 1'b0;   // head line fully dispatched
        r_out_ptr        <= r_out_ptr + 1'b1;
        r_head_pos       <= '0;
      end else begin
        r_head_pos <= w_pos_sum[WORD_POS_W-1:0];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_line[r_in_ptr] <= i_fetch_line;
      r_pc[r_in_ptr]   <= i_fetch_pc;
    end
  end

  // head line rotated so that slot 0 is the next word to dispatch
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_win
    logic [WORD_POS_W:0] w_pos;

    assign w_pos          = (WORD_POS_W+1)'(r_head_pos) + (WORD_POS_W+1)'(d);
    assign o_win_valid[d] = r_vld[r_out_ptr] & (w_pos < (WORD_POS_W+1)'(LINE_WORDS));
    assign o_win_word[d]  = r_line[r_out_ptr][w_pos[WORD_POS_W-1:0]*32 +: 32];
  end

  assign o_head_pc = r_pc[r_out_ptr] + VADDR_W'({r_head_pos, 2'b00});

endmodule

// File: ibuf_lane_pick.sv
`timescale 1ns/10ps

module ibuf_lane_pick import ibuf_pkg::*; #(
  parameter int NUM = 1
) (
  input  logic [DISP_SIZE-1:0] i_req,
  output logic [DISP_SIZE-1:0] o_pick
);

  // first NUM requests in slot order win
  always_comb begin
    int taken;
    taken  = 0;
    o_pick = '0;
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (i_req[i] && (taken < NUM)) begin
        o_pick[i] = 1'b1;
        taken     = taken + 1;
      end
    end
  end

endmodule

// File: ibuf_pkg.sv
package ibuf_pkg;

  localparam int VADDR_W         = 32;
  localparam int LINE_WORDS      = 4;
  localparam int LINE_W          = 128;
  localparam int DISP_SIZE       = 4;
  localparam int INST_BUF_SIZE   = 4;
  localparam int ARITH_DISP_SIZE = 2;
  localparam int MEM_DISP_SIZE   = 1;

  // derived widths
  localparam int WORD_POS_W = $clog2(LINE_WORDS);
  localparam int BUF_PTR_W  = $clog2(INST_BUF_SIZE);
  localparam int CNT_W      = $clog2(DISP_SIZE) + 1;   // 0..DISP_SIZE

  typedef enum logic [1:0] {
    CAT_ARITH = 2'd0,
    CAT_LD    = 2'd1,
    CAT_ST    = 2'd2,
    CAT_OTHER = 2'd3
  } inst_cat_t;

  // rv32 major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

endpackage

// File: ibuf_top.sv
`timescale 1ns/10ps

module ibuf_top import ibuf_pkg::*; (
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_fetch_valid,
  output logic                              o_fetch_ready,
  input  logic [VADDR_W-1:0]                i_fetch_pc,
  input  logic [LINE_W-1:0]                 i_fetch_line,

  output logic                              o_disp_valid,
  output logic [DISP_SIZE-1:0]              o_disp_slot_valid,
  output logic [DISP_SIZE-1:0][31:0]        o_disp_inst,
  output logic [DISP_SIZE-1:0][VADDR_W-1:0] o_disp_pc,
  output inst_cat_t [DISP_SIZE-1:0]         o_disp_cat,
  output logic [DISP_SIZE-1:0]              o_disp_rd_valid,
  output logic [DISP_SIZE-1:0]              o_disp_rs1_valid,
  output logic [DISP_SIZE-1:0]              o_disp_rs2_valid,
  input  logic                              i_disp_ready
);

  logic [DISP_SIZE-1:0][31:0] w_win_word;
  logic [DISP_SIZE-1:0]       w_win_valid;
  logic [VADDR_W-1:0]         w_head_pc;
  logic [CNT_W-1:0]           w_consume_cnt;

  inst_cat_t [DISP_SIZE-1:0]  w_cat;
  logic [DISP_SIZE-1:0]       w_rd_valid;
  logic [DISP_SIZE-1:0]       w_rs1_valid;
  logic [DISP_SIZE-1:0]       w_rs2_valid;
  logic [DISP_SIZE-1:0]       w_is_arith;
  logic [DISP_SIZE-1:0]       w_is_mem;

  logic [DISP_SIZE-1:0]       w_arith_pick;
  logic [DISP_SIZE-1:0]       w_mem_pick;

  ibuf_fetch_queue u_fetch_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_fetch_valid (i_fetch_valid),
    .o_fetch_ready (o_fetch_ready),
    .i_fetch_pc    (i_fetch_pc),
    .i_fetch_line  (i_fetch_line),
    .i_consume_cnt (w_consume_cnt),
    .o_win_word    (w_win_word),
    .o_win_valid   (w_win_valid),
    .o_head_pc     (w_head_pc)
  );

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_dec
    ibuf_decode_slot u_decode_slot (
      .i_word       (w_win_word[d]),
      .i_word_valid (w_win_valid[d]),
      .o_cat        (w_cat[d]),
      .o_rd_valid   (w_rd_valid[d]),
      .o_rs1_valid  (w_rs1_valid[d]),
      .o_rs2_valid  (w_rs2_valid[d]),
      .o_is_arith   (w_is_arith[d]),
      .o_is_mem     (w_is_mem[d])
    );
  end

  ibuf_lane_pick #(.NUM(ARITH_DISP_SIZE)) u_arith_pick (
    .i_req  (w_is_arith),
    .o_pick (w_arith_pick)
  );

  ibuf_lane_pick #(.NUM(MEM_DISP_SIZE)) u_mem_pick (
    .i_req  (w_is_mem),
    .o_pick (w_mem_pick)
  );

  ibuf_disp_merge u_disp_merge (
    .i_arith_pick      (w_arith_pick),
    .i_mem_pick        (w_mem_pick),
    .i_win_word        (w_win_word),
    .i_head_pc         (w_head_pc),
    .i_cat             (w_cat),
    .i_rd_valid        (w_rd_valid),
    .i_rs1_valid       (w_rs1_valid),
    .i_rs2_valid       (w_rs2_valid),
    .i_disp_ready      (i_disp_ready),
    .o_consume_cnt     (w_consume_cnt),
    .o_disp_valid      (o_disp_valid),
    .o_disp_slot_valid (o_disp_slot_valid),
    .o_disp_inst       (o_disp_inst),
    .o_disp_pc         (o_disp_pc),
    .o_disp_cat        (o_disp_cat),
    .o_disp_rd_valid   (o_disp_rd_valid),
    .o_disp_rs1_valid  (o_disp_rs1_valid),
    .o_disp_rs2_valid  (o_disp_rs2_valid)
  );

endmodule

// File: tb_ibuf.sv
`timescale 1ns/10ps

module tb_ibuf import ibuf_pkg::*;;

  localparam int N_LINES  = 48;
  localparam int WAIT_MAX = 2000;

  logic                              i_clk;
  logic                              i_reset_n;
  logic                              i_fetch_valid;
  logic                              o_fetch_ready;
  logic [VADDR_W-1:0]                i_fetch_pc;
  logic [LINE_W-1:0]                 i_fetch_line;
  logic                              o_disp_valid;
  logic [DISP_SIZE-1:0]              o_disp_slot_valid;
  logic [DISP_SIZE-1:0][31:0]        o_disp_inst;
  logic [DISP_SIZE-1:0][VADDR_W-1:0] o_disp_pc;
  inst_cat_t [DISP_SIZE-1:0]         o_disp_cat;
  logic [DISP_SIZE-1:0]              o_disp_rd_valid;
  logic [DISP_SIZE-1:0]              o_disp_rs1_valid;
  logic [DISP_SIZE-1:0]              o_disp_rs2_valid;
  logic                              i_disp_ready;

  integer             seed;
  int                 fetch_mode;   // 0 off, 1 random, 2 always
  int                 ready_mode;
  bit                 line_taken;
  logic [VADDR_W-1:0] next_pc;
  int                 lines_acc;

  // accepted lines and the word position in the head line
  logic [LINE_W-1:0]  mdl_line [$];
  logic [VADDR_W-1:0] mdl_pc [$];
  int                 mdl_pos;

  logic [6:0] known_opc [6] = '{OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC};
  logic [6:0] other_opc [4] = '{7'b1100011, 7'b1101111, 7'b1100111, 7'b1110011};

  ibuf_top ibuf_top_inst (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_fetch_valid     (i_fetch_valid),
    .o_fetch_ready     (o_fetch_ready),
    .i_fetch_pc        (i_fetch_pc),
    .i_fetch_line      (i_fetch_line),
    .o_disp_valid      (o_disp_valid),
    .o_disp_slot_valid (o_disp_slot_valid),
    .o_disp_inst       (o_disp_inst),
    .o_disp_pc         (o_disp_pc),
    .o_disp_cat        (o_disp_cat),
    .o_disp_rd_valid   (o_disp_rd_valid),
    .o_disp_rs1_valid  (o_disp_rs1_valid),
    .o_disp_rs2_valid  (o_disp_rs2_valid),
    .i_disp_ready      (i_disp_ready)
  );

  bind ibuf_top ibuf_checker u_ibuf_checker (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_ready (i_disp_ready),
    .i_disp_valid (o_disp_valid),
    .i_slot_valid (o_disp_slot_valid),
    .i_inst       (o_disp_inst),
    .i_pc         (o_disp_pc),
    .i_cat        (o_disp_cat)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR @ %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_on_timeout(string what);
    $display("Timeout @ %0t: gave up waiting for %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  endtask

  // {cat, rd, rs1, rs2} from the opcode
  function automatic logic [4:0] expect_decode(logic [31:0] word);
    logic [6:0] opc;
    logic [1:0] cat;
    opc = word[6:0];
    if (opc == OPC_LOAD) cat = CAT_LD;
    else if (opc == OPC_STORE) cat = CAT_ST;
    else if (opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC}) cat = CAT_ARITH;
    else cat = CAT_OTHER;
    return {cat, opc != OPC_STORE, !(opc inside {OPC_LUI, OPC_AUIPC}),
            opc inside {OPC_OP, OPC_STORE}};
  endfunction

  function automatic logic level_for(int mode);
    if (mode == 0) return 1'b0;
    if (mode == 2) return 1'b1;
    return ($random(seed) & 3) != 0;   // high 3 of 4 cycles
  endfunction

  task automatic make_line(output logic [LINE_W-1:0] line);
    logic [31:0] r;
    logic [6:0]  opc;
    for (int w = 0; w < LINE_WORDS; w++) begin
      r = $random(seed);
      if (($random(seed) & 7) == 0) opc = other_opc[$unsigned($random(seed)) % 4];
      else opc = known_opc[$unsigned($random(seed)) % 6];
      line[w*32 +: 32] = {r[31:7], opc};
    end
  endtask

  task automatic drive_inputs();
    logic [LINE_W-1:0] line;
    if (line_taken) begin   // new line only after the last one was accepted
      make_line(line);
      i_fetch_line <= line;
      i_fetch_pc   <= next_pc;
      next_pc      = next_pc + 16;
      line_taken   = 1'b0;
    end
    i_fetch_valid <= level_for(fetch_mode);
    i_disp_ready  <= level_for(ready_mode);
  endtask

  task automatic check_and_update();
    logic [DISP_SIZE-1:0] exp_mask;
    logic [31:0]          word;
    logic [4:0]           dec;
    int                   n_arith;
    int                   n_mem;
    int                   cnt;
    bit                   taking;
    exp_mask = '0;
    n_arith  = 0;
    n_mem    = 0;
    cnt      = 0;
    taking   = (mdl_line.size() > 0);
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (taking && (mdl_pos + d < LINE_WORDS)) begin
        dec = expect_decode(mdl_line[0][(mdl_pos + d)*32 +: 32]);
        if (dec[4:3] == CAT_LD || dec[4:3] == CAT_ST) begin
          taking = (n_mem < MEM_DISP_SIZE);
          n_mem++;
        end else begin
          taking = (n_arith < ARITH_DISP_SIZE);
          n_arith++;
        end
        exp_mask[d] = taking;
        cnt         = cnt + int'(taking);
      end else begin
        taking = 1'b0;   // group ends at the line end
      end
    end
    check_value("o_fetch_ready", mdl_line.size() < INST_BUF_SIZE, o_fetch_ready);
    check_value("o_disp_valid", cnt > 0, o_disp_valid);
    check_value("o_disp_slot_valid", exp_mask, o_disp_slot_valid);
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (exp_mask[d]) begin
        word = mdl_line[0][(mdl_pos + d)*32 +: 32];
        dec  = expect_decode(word);
        check_value($sformatf("o_disp_inst[%0d]", d), word, o_disp_inst[d]);
        check_value($sformatf("o_disp_pc[%0d]", d), mdl_pc[0] + 32'(4 * (mdl_pos + d)),
                    o_disp_pc[d]);
        check_value($sformatf("o_disp_cat[%0d]", d), dec[4:3], o_disp_cat[d]);
        check_value($sformatf("o_disp_rd_valid[%0d]", d), dec[2], o_disp_rd_valid[d]);
        check_value($sformatf("o_disp_rs1_valid[%0d]", d), dec[1], o_disp_rs1_valid[d]);
        check_value($sformatf("o_disp_rs2_valid[%0d]", d), dec[0], o_disp_rs2_valid[d]);
      end
    end
    if (o_disp_valid && i_disp_ready) begin
      mdl_pos = mdl_pos + cnt;
      if (mdl_pos >= LINE_WORDS) begin
        void'(mdl_line.pop_front());
        void'(mdl_pc.pop_front());
        mdl_pos = 0;
      end
    end
    if (i_fetch_valid && o_fetch_ready) begin
      mdl_line.push_back(i_fetch_line);
      mdl_pc.push_back(i_fetch_pc);
      lines_acc++;
      line_taken = 1'b1;
    end
  endtask

  // drive on the rising edge, check on the falling edge
  task automatic run_cycle();
    @(posedge i_clk);
    drive_inputs();
    @(negedge i_clk);
    check_and_update();
  endtask

  task automatic wait_drain(string what);
    int n;
    n = 0;
    while (mdl_line.size() > 0) begin
      if (n == WAIT_MAX) abort_on_timeout(what);
      run_cycle();
      n++;
    end
  endtask

  initial begin
    int n;
    int start;
    i_reset_n     = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_pc    = '0;
    i_fetch_line  = '0;
    i_disp_ready  = 1'b0;
    seed          = 42906;
    fetch_mode    = 0;
    ready_mode    = 0;
    line_taken    = 1'b1;
    next_pc       = 32'h0000_1000;
    lines_acc     = 0;
    mdl_pos       = 0;

    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_value("o_disp_valid", 1'b0, o_disp_valid);
    check_value("o_fetch_ready", 1'b1, o_fetch_ready);

    fetch_mode = 1;
    ready_mode = 1;
    n = 0;
    while (lines_acc < N_LINES) begin
      if (n == WAIT_MAX) abort_on_timeout("random fetch lines to be accepted");
      run_cycle();
      n++;
    end
    fetch_mode = 0;
    ready_mode = 2;
    wait_drain("the queue to drain after random traffic");

    // fill the queue with dispatch stalled
    fetch_mode = 2;
    ready_mode = 0;
    start      = lines_acc;
    n          = 0;
    while (o_fetch_ready) begin
      if (n == WAIT_MAX) abort_on_timeout("o_fetch_ready to drop");
      run_cycle();
      n++;
    end
    check_value("lines accepted until full", INST_BUF_SIZE, lines_acc - start);
    repeat (6) run_cycle();   // held line waits for a free entry
    ready_mode = 2;
    n          = 0;
    while (lines_acc < start + INST_BUF_SIZE + 1) begin
      if (n == WAIT_MAX) abort_on_timeout("the held fetch line to be accepted");
      run_cycle();
      n++;
    end
    fetch_mode = 0;
    wait_drain("the full queue to drain");
    run_cycle();

    check_value("o_disp_valid", 1'b0, o_disp_valid);
    check_value("o_fetch_ready", 1'b1, o_fetch_ready);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
